// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mips_periph_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# a simulator that exits with an error also counts as a failed run
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+verilog
verilog/mips_bus_pkg.sv
verilog/timer_pkg.sv
verilog/system_bridge.sv
verilog/timer_counter.sv
verilog/mips_periph_top.sv
testbench/mips_periph_properties.sv
testbench/mips_periph_tb.sv

// ==== testbench/mips_periph_properties.sv ====
`timescale 1ns/10ps
`include "mips_bus_config.svh"

module mips_periph_properties (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   ext_irq,
	input mips_bus_pkg::bus_req_t core_req,
	input mips_bus_pkg::byteen_t  dm_byteen,
	input mips_bus_pkg::irq_vec_t irq_vec
);

	logic in_dm;

	assign in_dm = (core_req.addr >= `MIPS_DM_LO) && (core_req.addr <= `MIPS_DM_HI);

	a_byteen_needs_write: assert property (@(posedge clk) disable iff (!arst_n)
		!core_req.we |-> dm_byteen == '0)
		else $error("byte enables active without a write");

	// timer and unmapped accesses must never touch memory lanes
	a_byteen_in_window: assert property (@(posedge clk) disable iff (!arst_n)
		!in_dm |-> dm_byteen == '0)
		else $error("byte enables active outside the data memory window");

	a_irq_upper_zero: assert property (@(posedge clk) irq_vec[5:3] == 3'b000)
		else $error("unused interrupt lines are not zero");

	a_irq_ext: assert property (@(posedge clk) irq_vec[2] == ext_irq)
		else $error("external interrupt line does not follow ext_irq");

endmodule

bind mips_periph_top mips_periph_properties u_properties (
	.clk       (clk),
	.arst_n    (arst_n),
	.ext_irq   (ext_irq),
	.core_req  (core_req),
	.dm_byteen (dm_byteen),
	.irq_vec   (irq_vec)
);

// ==== testbench/mips_periph_tb.sv ====
`timescale 1ns/10ps
`include "mips_bus_config.svh"

module mips_periph_tb;

	import mips_bus_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DM_WORDS = 3072;
	// all tests together take roughly 400 cycles even with the largest presets
	localparam int MAX_CYCLES = 3000;

	logic      clk;
	logic      arst_n;
	logic      ext_irq;
	bus_req_t  core_req;
	bus_word_t dm_rdata;
	bus_word_t core_rdata;
	bus_addr_t dm_addr;
	bus_word_t dm_wdata;
	byteen_t   dm_byteen;
	irq_vec_t  irq_vec;

	bus_word_t   dm_mem [DM_WORDS];
	bus_word_t   shadow [DM_WORDS];
	logic [31:0] rng;
	byteen_t     seen_byteen;
	int          cycle_count;
	int          check_count;
	int          error_count;

	mips_periph_top u_mips_periph_top (
		.clk        (clk),
		.arst_n     (arst_n),
		.ext_irq    (ext_irq),
		.core_req   (core_req),
		.dm_rdata   (dm_rdata),
		.core_rdata (core_rdata),
		.dm_addr    (dm_addr),
		.dm_wdata   (dm_wdata),
		.dm_byteen  (dm_byteen),
		.irq_vec    (irq_vec)
	);

	// word addresses past the end of the data memory model read as zero
	assign dm_rdata = (dm_addr[13:2] < DM_WORDS) ? dm_mem[dm_addr[13:2]] : '0;

	always @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (dm_byteen[b] && dm_addr[13:2] < DM_WORDS) begin
				dm_mem[dm_addr[13:2]][8*b +: 8] = dm_wdata[8*b +: 8];
			end
		end
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic bus_addr_t tc_addr(input int t, input logic [1:0] off);
		bus_addr_t base;
		base = (t == 0) ? `MIPS_TC0_BASE : `MIPS_TC1_BASE;
		return base + {28'd0, off, 2'b00};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (error_count == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, error_count - errs_before);
		end
	endtask

	// each call makes one access and samples it a quarter period after driving it
	task automatic bus_access(input logic we, input bus_addr_t addr, input bus_word_t wdata,
			input byteen_t be, output bus_word_t rdata);
		@(negedge clk);
		core_req.we     = we;
		core_req.byteen = be;
		core_req.addr   = addr;
		core_req.wdata  = wdata;
		#(CLK_PERIOD / 4);
		rdata       = core_rdata;
		seen_byteen = dm_byteen;
		@(negedge clk);
		core_req = '0;
	endtask

	task automatic bus_write(input bus_addr_t addr, input bus_word_t wdata, input byteen_t be);
		bus_word_t unused;
		bus_access(1'b1, addr, wdata, be, unused);
	endtask

	task automatic bus_read(input bus_addr_t addr, output bus_word_t rdata);
		bus_access(1'b0, addr, '0, '0, rdata);
	endtask

	task automatic test_dm_path();
		int        errs;
		int        idx [16];
		bus_word_t data;
		byteen_t   be;
		bus_word_t rd;
		errs = error_count;
		for (int i = 0; i < 16; i++) begin
			rng = xorshift32(rng);
			idx[i] = int'(rng % DM_WORDS);
			rng = xorshift32(rng);
			data = rng;
			rng = xorshift32(rng);
			be = rng[7:4];
			for (int b = 0; b < 4; b++) begin
				if (be[b]) begin
					shadow[idx[i]][8*b +: 8] = data[8*b +: 8];
				end
			end
			bus_write(bus_addr_t'(idx[i]) << 2, data, be);
			check_value("dm_byteen", seen_byteen, be);
		end
		for (int i = 0; i < 16; i++) begin
			bus_read(bus_addr_t'(idx[i]) << 2, rd);
			check_value("core_rdata", rd, shadow[idx[i]]);
		end
		report_test("data memory path", errs);
	endtask

	task automatic test_decode();
		int        errs;
		bus_addr_t addrs [6];
		bus_word_t rd;
		errs = error_count;
		// most of these alias onto low memory words if the decode leaks
		addrs = '{32'h0000_3000, 32'h0000_4010, 32'h0001_0020, 32'h8000_0004,
			`MIPS_TC0_BASE + 32'd4, `MIPS_TC1_BASE + 32'd4};
		for (int i = 0; i < 6; i++) begin
			bus_write(addrs[i], 32'hdead_beef, 4'hf);
			check_value("dm_byteen", seen_byteen, 0);
		end
		for (int i = 0; i < 4; i++) begin
			bus_read(addrs[i], rd);
			check_value("core_rdata", rd, 0);
		end
		for (int i = 0; i < DM_WORDS; i++) begin
			check_value("dm_mem", dm_mem[i], shadow[i]);
		end
		report_test("address decode", errs);
	endtask

	task automatic test_timer_regs();
		int        errs;
		bus_word_t pre [2];
		bus_word_t ctl [2];
		bus_word_t rd;
		errs = error_count;
		for (int t = 0; t < 2; t++) begin
			rng = xorshift32(rng);
			pre[t] = rng;
			rng = xorshift32(rng);
			// enable stays clear so neither timer starts counting
			ctl[t] = rng & ~32'h1;
			bus_write(tc_addr(t, `MIPS_TC_PRESET), pre[t], 4'hf);
			bus_write(tc_addr(t, `MIPS_TC_CTRL), ctl[t], 4'hf);
		end
		for (int t = 0; t < 2; t++) begin
			bus_read(tc_addr(t, `MIPS_TC_PRESET), rd);
			check_value("preset", rd, pre[t]);
			bus_read(tc_addr(t, `MIPS_TC_CTRL), rd);
			check_value("ctrl", rd, ctl[t]);
			// no timer has run yet so COUNT still holds its reset value
			bus_read(tc_addr(t, `MIPS_TC_COUNT), rd);
			check_value("count", rd, 0);
			rng = xorshift32(rng);
			bus_write(tc_addr(t, `MIPS_TC_COUNT), rng | 32'h1, 4'hf);
			bus_read(tc_addr(t, `MIPS_TC_COUNT), rd);
			check_value("count", rd, 0);
			bus_write(tc_addr(t, `MIPS_TC_CTRL), 32'h0, 4'hf);
		end
		report_test("timer registers", errs);
	endtask

	task automatic run_one_shot(input int t, input bus_word_t p, input logic im);
		bus_word_t rd;
		bus_word_t exp_cnt;
		bus_write(tc_addr(t, `MIPS_TC_PRESET), p, 4'hf);
		bus_write(tc_addr(t, `MIPS_TC_CTRL), im ? 32'h9 : 32'h1, 4'hf);
		// k counts clock edges after the enabling write
		for (int k = 1; k <= int'(p) + 12; k++) begin
			@(negedge clk);
			core_req.addr = tc_addr(t, `MIPS_TC_COUNT);
			#(CLK_PERIOD / 4);
			if (k >= 2) begin
				exp_cnt = (k - 2 < p) ? p - bus_word_t'(k - 2) : '0;
				check_value("count", core_rdata, exp_cnt);
			end
			check_value($sformatf("irq_vec[%0d]", t), irq_vec[t], im && k >= int'(p) + 2);
			check_value($sformatf("irq_vec[%0d]", 1 - t), irq_vec[1 - t], 0);
		end
		bus_read(tc_addr(t, `MIPS_TC_CTRL), rd);
		check_value("ctrl", rd, im ? 32'h8 : 32'h0);
		bus_write(tc_addr(t, `MIPS_TC_CTRL), 32'h0, 4'hf);
		check_value($sformatf("irq_vec[%0d]", t), irq_vec[t], 0);
	endtask

	task automatic run_reload(input int t, input bus_word_t p);
		int pulses;
		pulses = 0;
		bus_write(tc_addr(t, `MIPS_TC_PRESET), p, 4'hf);
		bus_write(tc_addr(t, `MIPS_TC_CTRL), 32'hb, 4'hf);
		for (int k = 1; k <= 4 * (int'(p) + 2) + 1; k++) begin
			@(negedge clk);
			check_value($sformatf("irq_vec[%0d]", t), irq_vec[t], k % (int'(p) + 2) == 0);
			pulses += int'(irq_vec[t]);
		end
		check_value("pulse count", pulses, 4);
		bus_write(tc_addr(t, `MIPS_TC_CTRL), 32'h0, 4'hf);
		for (int k = 0; k < 2 * (int'(p) + 2); k++) begin
			@(negedge clk);
			check_value($sformatf("irq_vec[%0d]", t), irq_vec[t], 0);
		end
	endtask

	task automatic test_timer_modes();
		int errs;
		errs = error_count;
		rng = xorshift32(rng);
		run_one_shot(0, 2 + rng % 16, 1'b1);
		rng = xorshift32(rng);
		run_one_shot(1, 2 + rng % 16, 1'b1);
		run_one_shot(0, 4, 1'b0);
		report_test("one-shot mode", errs);
		errs = error_count;
		rng = xorshift32(rng);
		run_reload(0, 1 + rng % 16);
		run_reload(1, 3);
		report_test("auto-reload mode", errs);
	endtask

	task automatic test_ext_irq();
		int errs;
		errs = error_count;
		// timer0 holds a sticky interrupt while the external line toggles
		bus_write(tc_addr(0, `MIPS_TC_PRESET), 32'h1, 4'hf);
		bus_write(tc_addr(0, `MIPS_TC_CTRL), 32'h9, 4'hf);
		repeat (3) @(negedge clk);
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			rng = xorshift32(rng);
			ext_irq = rng[0];
			#(CLK_PERIOD / 4);
			check_value("irq_vec[2]", irq_vec[2], ext_irq);
			check_value("irq_vec[1:0]", irq_vec[1:0], 2'b01);
			check_value("irq_vec[5:3]", irq_vec[5:3], 0);
		end
		@(negedge clk);
		ext_irq = 1'b0;
		bus_write(tc_addr(0, `MIPS_TC_CTRL), 32'h0, 4'hf);
		report_test("external interrupt", errs);
	endtask

	initial begin
		rng = 32'hcce4_29db;
		cycle_count = 0;
		check_count = 0;
		error_count = 0;
		arst_n = 1'b0;
		ext_irq = 1'b0;
		core_req = '0;
		for (int i = 0; i < DM_WORDS; i++) begin
			dm_mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
			shadow[i] = dm_mem[i];
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		test_dm_path();
		test_decode();
		test_timer_regs();
		test_timer_modes();
		test_ext_irq();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verilog/mips_bus_config.svh ====
`ifndef MIPS_BUS_CONFIG_SVH
`define MIPS_BUS_CONFIG_SVH

// widths of the core data port
`define MIPS_DATA_W 32
`define MIPS_ADDR_W 32
`define MIPS_BYTEEN_W (`MIPS_DATA_W / 8)
`define MIPS_IRQ_W 6

// data memory window, both ends inclusive
`define MIPS_DM_LO 32'h0000_0000
`define MIPS_DM_HI 32'h0000_2FFF

// each timer occupies three words starting at its base
`define MIPS_TC0_BASE 32'h0000_7F00
`define MIPS_TC1_BASE 32'h0000_7F10
`define MIPS_TC_SIZE 32'd12

// word offsets of the timer registers inside a window
`define MIPS_TC_OFF_W 2
`define MIPS_TC_CTRL 2'd0
`define MIPS_TC_PRESET 2'd1
`define MIPS_TC_COUNT 2'd2

`endif

// ==== verilog/mips_bus_pkg.sv ====
`include "mips_bus_config.svh"

package mips_bus_pkg;

	// byte address and data word of the core data port
	typedef logic [`MIPS_ADDR_W-1:0] bus_addr_t;
	typedef logic [`MIPS_DATA_W-1:0] bus_word_t;

	// one enable per byte lane of a data word
	typedef logic [`MIPS_BYTEEN_W-1:0] byteen_t;

	// hardware interrupt lines as the core samples them
	typedef logic [`MIPS_IRQ_W-1:0] irq_vec_t;

	// register index inside a timer window
	typedef logic [`MIPS_TC_OFF_W-1:0] word_off_t;

	// one data access as it leaves the core
	typedef struct packed {
		logic      we;
		byteen_t   byteen;
		bus_addr_t addr;
		bus_word_t wdata;
	} bus_req_t;

	// the same access after decode, as a single timer sees it
	// we is only set when the write falls inside that timer's window
	typedef struct packed {
		logic      we;
		word_off_t offset;
		bus_word_t wdata;
	} periph_req_t;

endpackage

// ==== verilog/mips_periph_top.sv ====
`timescale 1ns/10ps

module mips_periph_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    ext_irq,
	input  mips_bus_pkg::bus_req_t  core_req,
	input  mips_bus_pkg::bus_word_t dm_rdata,
	output mips_bus_pkg::bus_word_t core_rdata,
	output mips_bus_pkg::bus_addr_t dm_addr,
	output mips_bus_pkg::bus_word_t dm_wdata,
	output mips_bus_pkg::byteen_t   dm_byteen,
	output mips_bus_pkg::irq_vec_t  irq_vec
);

	import mips_bus_pkg::*;

	// decoded accesses toward each timer
	periph_req_t tc0_req;
	periph_req_t tc1_req;

	// timer read data back to the bridge
	bus_word_t tc0_rdata;
	bus_word_t tc1_rdata;

	logic tc0_irq;
	logic tc1_irq;

	system_bridge u_bridge (
		.core_req   (core_req),
		.dm_rdata   (dm_rdata),
		.tc0_rdata  (tc0_rdata),
		.tc1_rdata  (tc1_rdata),
		.dm_addr    (dm_addr),
		.dm_wdata   (dm_wdata),
		.dm_byteen  (dm_byteen),
		.tc0_req    (tc0_req),
		.tc1_req    (tc1_req),
		.core_rdata (core_rdata)
	);

	timer_counter u_timer0 (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (tc0_req),
		.rdata  (tc0_rdata),
		.irq    (tc0_irq)
	);

	timer_counter u_timer1 (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (tc1_req),
		.rdata  (tc1_rdata),
		.irq    (tc1_irq)
	);

	// the core expects timers on the two lowest lines and the external pin above them
	// lines 3 to 5 have no source in this system
	assign irq_vec = {3'b000, ext_irq, tc1_irq, tc0_irq};

endmodule

// ==== verilog/system_bridge.sv ====
`timescale 1ns/10ps
`include "mips_bus_config.svh"

module system_bridge (
	input  mips_bus_pkg::bus_req_t    core_req,
	input  mips_bus_pkg::bus_word_t   dm_rdata,
	input  mips_bus_pkg::bus_word_t   tc0_rdata,
	input  mips_bus_pkg::bus_word_t   tc1_rdata,
	output mips_bus_pkg::bus_addr_t   dm_addr,
	output mips_bus_pkg::bus_word_t   dm_wdata,
	output mips_bus_pkg::byteen_t     dm_byteen,
	output mips_bus_pkg::periph_req_t tc0_req,
	output mips_bus_pkg::periph_req_t tc1_req,
	output mips_bus_pkg::bus_word_t   core_rdata
);

	import mips_bus_pkg::*;

	// distance of the access from the start of each window
	bus_addr_t dm_rel;
	bus_addr_t tc0_rel;
	bus_addr_t tc1_rel;

	logic sel_dm;
	logic sel_tc0;
	logic sel_tc1;

	// builds the request one timer sees from the core access
	function automatic periph_req_t to_periph(input bus_req_t req, input logic sel,
			input bus_addr_t rel);
		periph_req_t p;
		p.we     = req.we & sel;
		p.offset = rel[3:2];
		p.wdata  = req.wdata;
		return p;
	endfunction

	// addresses below a base wrap to large values, so one compare covers both ends
	assign dm_rel  = core_req.addr - `MIPS_DM_LO;
	assign tc0_rel = core_req.addr - `MIPS_TC0_BASE;
	assign tc1_rel = core_req.addr - `MIPS_TC1_BASE;

	assign sel_dm  = (dm_rel <= (`MIPS_DM_HI - `MIPS_DM_LO));
	assign sel_tc0 = (tc0_rel < `MIPS_TC_SIZE);
	assign sel_tc1 = (tc1_rel < `MIPS_TC_SIZE);

	// address and data go to the memory pins unchanged
	assign dm_addr  = core_req.addr;
	assign dm_wdata = core_req.wdata;

	// only writes that decode to memory may carry byte enables
	assign dm_byteen = (core_req.we && sel_dm) ? core_req.byteen : '0;

	assign tc0_req = to_periph(core_req, sel_tc0, tc0_rel);
	assign tc1_req = to_periph(core_req, sel_tc1, tc1_rel);

	// the windows never overlap, so the order here is only for clarity
	always_comb begin
		if (sel_dm) begin
			core_rdata = dm_rdata;
		end else if (sel_tc0) begin
			core_rdata = tc0_rdata;
		end else if (sel_tc1) begin
			core_rdata = tc1_rdata;
		end else begin
			core_rdata = '0;
		end
	end

endmodule

// ==== verilog/timer_counter.sv ====
`timescale 1ns/10ps
`include "mips_bus_config.svh"

module timer_counter (
	input  logic                      clk,
	input  logic                      arst_n,
	input  mips_bus_pkg::periph_req_t req,
	output mips_bus_pkg::bus_word_t   rdata,
	output logic                      irq
);

	import mips_bus_pkg::*;
	import timer_pkg::*;

	// software visible registers
	tc_ctrl_t  ctrl;
	bus_word_t preset;
	bus_word_t count;

	tc_state_t state;
	tc_state_t state_nxt;
	logic      irq_flag;

	logic      ctrl_we;
	logic      preset_we;
	tc_mode_t  mode_eff;
	bus_word_t load_val;

	// COUNT is read-only, so a write there has no strobe
	assign ctrl_we   = req.we && (req.offset == `MIPS_TC_CTRL);
	assign preset_we = req.we && (req.offset == `MIPS_TC_PRESET);

	// the two unused mode codes behave as one-shot
	assign mode_eff = (ctrl.mode == TC_MODE_RELOAD) ? TC_MODE_RELOAD : TC_MODE_ONESHOT;

	// a preset of zero counts like a preset of one
	assign load_val = (preset == '0) ? bus_word_t'(1) : preset;

	always_comb begin
		state_nxt = state;
		if (!ctrl.enable) begin
			// dropping enable parks the counter wherever it was
			state_nxt = IDLE;
		end else begin
			case (state)
				IDLE: begin
					state_nxt = LOAD;
				end
				LOAD: begin
					state_nxt = CNT;
				end
				CNT: begin
					if (count <= bus_word_t'(1)) begin
						state_nxt = INT;
					end
				end
				INT: begin
					if (mode_eff == TC_MODE_RELOAD) begin
						state_nxt = LOAD;
					end else begin
						state_nxt = IDLE;
					end
				end
				default: begin
					state_nxt = IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= IDLE;
			ctrl     <= '0;
			preset   <= '0;
			count    <= '0;
			irq_flag <= 1'b0;
		end else begin
			state <= state_nxt;

			case (state)
				LOAD: begin
					if (ctrl.enable) begin
						count <= load_val;
					end
				end
				CNT: begin
					if (ctrl.enable) begin
						count <= count - bus_word_t'(1);
					end
				end
				INT: begin
					// auto-reload keeps the flag for this one cycle only
					if (mode_eff == TC_MODE_RELOAD) begin
						irq_flag <= 1'b0;
					end else begin
						ctrl.enable <= 1'b0;
					end
				end
				default: begin
				end
			endcase

			// flag rises on the same edge that takes COUNT to zero
			if (state == CNT && state_nxt == INT) begin
				irq_flag <= 1'b1;
			end

			// a bus write wins over anything the counter did on this edge
			if (ctrl_we) begin
				ctrl     <= tc_ctrl_t'(req.wdata);
				irq_flag <= 1'b0;
			end
			if (preset_we) begin
				preset <= req.wdata;
			end
		end
	end

	always_comb begin
		case (req.offset)
			`MIPS_TC_CTRL:   rdata = ctrl;
			`MIPS_TC_PRESET: rdata = preset;
			`MIPS_TC_COUNT:  rdata = count;
			default:         rdata = '0;
		endcase
	end

	assign irq = irq_flag & ctrl.im;

endmodule

// ==== verilog/timer_pkg.sv ====
`include "mips_bus_config.svh"

package timer_pkg;

	// counter sequencing
	// INT is the single cycle in which the terminal count is seen
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		CNT,
		INT
	} tc_state_t;

	// counting mode held in CTRL
	typedef logic [1:0] tc_mode_t;

	// one-shot stops after the first terminal count and keeps its flag
	localparam tc_mode_t TC_MODE_ONESHOT = 2'd0;

	// auto-reload restarts from PRESET and pulses its flag once per period
	localparam tc_mode_t TC_MODE_RELOAD = 2'd1;

	// layout of the CTRL register, enable in bit 0
	typedef struct packed {
		logic [`MIPS_DATA_W-5:0] reserved;
		logic                    im;
		tc_mode_t                mode;
		logic                    enable;
	} tc_ctrl_t;

endpackage
